//--- src.f
hw/host_bridge_pkg.sv
hw/stream_fifo.sv
hw/downstream_channel.sv
hw/upstream_channel.sv
hw/stream_eof_tracker.sv
hw/host_bridge_top.sv
dv/tb_host_bridge.sv

//--- Makefile
# Verilator build for the host message bridge
VERILATOR ?= verilator
TOP       ?= tb_host_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Result comes from the log, not the simulator exit code
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_host_bridge.sv
`default_nettype none
`timescale 1ns/1ps

module tb_host_bridge;

  // Words driven per phase set the watchdog limit too
  localparam int N_ORDER         = 40;
  localparam int N_BP            = host_bridge_pkg::WR_FIFO_DEPTH;
  localparam int N_LOOP          = 12;
  localparam int N_UP_CLOSED     = 4;
  localparam int N_UP_OPEN       = host_bridge_pkg::RD_FIFO_DEPTH + 3;
  localparam int NUM_WORDS       = N_ORDER + N_BP + N_LOOP + N_UP_CLOSED + N_UP_OPEN + 1;
  localparam int WATCHDOG_CYCLES = NUM_WORDS * 4 + 200;

  logic bus_clk, rst;
  logic wr_wren, wr_full, wr_open;
  logic rd_rden, rd_empty, rd_open, rd_eof;
  logic loop_rden, loop_empty, loop_eof;
  logic pc_msg_empty, pc_msg_ack;
  logic fpga_msg_valid, fpga_msg_full, fpga_msg_lost, app_done;
  host_bridge_pkg::xb_word_t wr_data, rd_data, loop_data, pc_msg, fpga_msg;

  // Reference model of the three FIFOs and the status registers
  host_bridge_pkg::xb_word_t wr_q[$];
  host_bridge_pkg::xb_word_t loop_q[$];
  host_bridge_pkg::xb_word_t rd_q[$];
  logic lost_m, rd_eof_m, loop_eof_m;

  int errors = 0;
  logic [31:0] lcg_state = 32'h967e7e0e;
  logic saw_wr_full = 1'b0;
  logic saw_loop_bp = 1'b0;
  logic saw_closed_drop = 1'b0;
  logic saw_lost = 1'b0;
  logic saw_term_eof = 1'b0;
  logic saw_done_eof = 1'b0;
  logic saw_loop_eof = 1'b0;

  host_bridge_top UUT (.*);

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic require_seen(input logic seen, input string what);
    assert (seen) else begin
      $display("Scenario never reached: %s", what);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge bus_clk);
    #1;
  endtask

  task automatic clear_strobes();
    wr_wren        = 1'b0;
    pc_msg_ack     = 1'b0;
    loop_rden      = 1'b0;
    rd_rden        = 1'b0;
    fpga_msg_valid = 1'b0;
    app_done       = 1'b0;
  endtask

  // Empty every stream the DUT still holds
  task automatic drain_streams();
    while (!pc_msg_empty || !loop_empty || !rd_empty) begin
      pc_msg_ack = !pc_msg_empty;
      loop_rden  = !loop_empty;
      rd_rden    = !rd_empty;
      next_cycle();
    end
    clear_strobes();
  endtask

  // **************************************************************************
  // Reference model and checks
  // **************************************************************************

  always @(posedge bus_clk) begin
    int wr_n;
    int loop_n;
    int rd_n;
    logic exp_pc_empty;
    logic term;
    if (rst) begin
      wr_q.delete();
      loop_q.delete();
      rd_q.delete();
      lost_m     = 1'b0;
      rd_eof_m   = 1'b0;
      loop_eof_m = 1'b0;
    end else begin
      wr_n   = wr_q.size();
      loop_n = loop_q.size();
      rd_n   = rd_q.size();
      exp_pc_empty = (wr_n == 0) || (loop_n == host_bridge_pkg::LOOP_FIFO_DEPTH);
      assert (wr_full == (wr_n == host_bridge_pkg::WR_FIFO_DEPTH))
        else report_err($sformatf("wr_full is %b with %0d words queued", wr_full, wr_n));
      assert (pc_msg_empty == exp_pc_empty)
        else report_err($sformatf("pc_msg_empty is %b, expected %b", pc_msg_empty, exp_pc_empty));
      assert (loop_empty == (loop_n == 0)) else report_err("loop_empty mismatch");
      assert (rd_empty == (rd_n == 0)) else report_err("rd_empty mismatch");
      assert (fpga_msg_full == (rd_n == host_bridge_pkg::RD_FIFO_DEPTH))
        else report_err("fpga_msg_full mismatch");
      assert (fpga_msg_lost == lost_m) else report_err("fpga_msg_lost mismatch");
      assert (rd_eof == rd_eof_m) else report_err($sformatf("rd_eof is %b", rd_eof));
      assert (loop_eof == loop_eof_m) else report_err($sformatf("loop_eof is %b", loop_eof));
      if (!exp_pc_empty) begin
        assert (pc_msg == wr_q[0])
          else report_err($sformatf("pc_msg %h, expected %h", pc_msg, wr_q[0]));
      end
      if (loop_n > 0) begin
        assert (loop_data == loop_q[0])
          else report_err($sformatf("loop_data %h, expected %h", loop_data, loop_q[0]));
      end
      if (rd_n > 0) begin
        assert (rd_data == rd_q[0])
          else report_err($sformatf("rd_data %h, expected %h", rd_data, rd_q[0]));
      end

      term = !exp_pc_empty && (rd_n == 0) && (wr_q[0] == host_bridge_pkg::TERMINATOR_WORD);
      if (!rd_open)
        rd_eof_m = 1'b0;
      else if (term || app_done)
        rd_eof_m = 1'b1;
      loop_eof_m = !wr_open && (loop_n == 0);
      if (fpga_msg_valid && rd_open && rd_n == host_bridge_pkg::RD_FIFO_DEPTH)
        lost_m = 1'b1;

      // Queue updates all use the occupancy from before this edge
      if (loop_rden && loop_n > 0)
        void'(loop_q.pop_front());
      if (wr_wren && wr_n < host_bridge_pkg::WR_FIFO_DEPTH)
        wr_q.push_back(wr_data);
      if (pc_msg_ack && !exp_pc_empty)
        loop_q.push_back(wr_q.pop_front());
      if (rd_rden && rd_n > 0)
        void'(rd_q.pop_front());
      if (fpga_msg_valid && rd_open && rd_n < host_bridge_pkg::RD_FIFO_DEPTH)
        rd_q.push_back(fpga_msg);

      if (wr_full)
        saw_wr_full = 1'b1;
      if (exp_pc_empty && wr_n > 0)
        saw_loop_bp = 1'b1;
      if (fpga_msg_valid && !rd_open)
        saw_closed_drop = 1'b1;
      if (lost_m)
        saw_lost = 1'b1;
      if (rd_open && term)
        saw_term_eof = 1'b1;
      if (rd_open && app_done && !term)
        saw_done_eof = 1'b1;
      if (loop_eof_m)
        saw_loop_eof = 1'b1;
    end
  end

  a_lost_sticky: assert property (
    @(posedge bus_clk) disable iff (rst) fpga_msg_lost |=> fpga_msg_lost
  ) else report_err("fpga_msg_lost cleared without reset");

  a_loop_eof_follows: assert property (
    @(posedge bus_clk) disable iff (rst) (!wr_open && loop_empty) |=> loop_eof
  ) else report_err("loop_eof low after drained close");

  // **************************************************************************
  // Stimulus
  // **************************************************************************

  initial begin
    int i;
    int sent;
    logic [31:0] r;
    rst = 1'b1;
    clear_strobes();
    wr_data  = '0;
    fpga_msg = '0;
    wr_open  = 1'b1;
    rd_open  = 1'b0;
    repeat (2) @(posedge bus_clk);
    #1;
    rst     = 1'b0;
    rd_open = 1'b1;

    // Random host words, random acks and loopback reads
    sent = 0;
    while (sent < N_ORDER || !pc_msg_empty || !loop_empty) begin
      r = next_rand();
      wr_wren    = (sent < N_ORDER) && !wr_full && (r[1:0] != 2'd0);
      wr_data    = next_rand();
      pc_msg_ack = !pc_msg_empty && (r[3:2] != 2'd0);
      loop_rden  = !loop_empty && (r[5:4] != 2'd0);
      if (wr_wren)
        sent++;
      next_cycle();
    end
    clear_strobes();

    // Fill the write FIFO with nobody acking
    for (i = 0; i < N_BP; i++) begin
      wr_wren = 1'b1;
      wr_data = next_rand();
      next_cycle();
    end
    wr_wren = 1'b0;
    assert (wr_full) else report_err("wr_full low after filling the write FIFO");
    drain_streams();

    // Ack until the loopback FIFO blocks the application
    for (i = 0; i < N_LOOP; i++) begin
      wr_wren    = 1'b1;
      wr_data    = next_rand();
      pc_msg_ack = !pc_msg_empty;
      next_cycle();
    end
    wr_wren    = 1'b0;
    pc_msg_ack = 1'b0;
    drain_streams();

    // Upstream pushes with the read stream closed and then past full
    rd_open = 1'b0;
    for (i = 0; i < N_UP_CLOSED + N_UP_OPEN; i++) begin
      if (i == N_UP_CLOSED)
        rd_open = 1'b1;
      fpga_msg_valid = 1'b1;
      fpga_msg       = next_rand();
      next_cycle();
    end
    fpga_msg_valid = 1'b0;
    drain_streams();

    // Terminator at the head raises rd_eof
    wr_wren = 1'b1;
    wr_data = host_bridge_pkg::TERMINATOR_WORD;
    next_cycle();
    wr_wren = 1'b0;
    while (!rd_eof)
      next_cycle();
    rd_open    = 1'b0;
    pc_msg_ack = 1'b1;
    next_cycle();
    pc_msg_ack = 1'b0;
    rd_open    = 1'b1;
    app_done   = 1'b1;
    next_cycle();
    app_done = 1'b0;
    rd_open  = 1'b0;
    next_cycle();

    // Close host writes and drain the loopback copy
    wr_open = 1'b0;
    while (!loop_empty) begin
      loop_rden = 1'b1;
      next_cycle();
    end
    loop_rden = 1'b0;
    while (!loop_eof)
      next_cycle();
    next_cycle();

    require_seen(saw_wr_full, "write FIFO full");
    require_seen(saw_loop_bp, "loopback back-pressure");
    require_seen(saw_closed_drop, "push with read stream closed");
    require_seen(saw_lost, "lost upstream word");
    require_seen(saw_term_eof, "rd_eof from terminator");
    require_seen(saw_done_eof, "rd_eof from app_done");
    require_seen(saw_loop_eof, "loop_eof");
    $display("Checks done: %0d errors", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Checks done: %0d errors", errors);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/host_bridge_top.sv
`default_nettype none
`timescale 1ns/1ps

module host_bridge_top (
  input  wire                       bus_clk,
  input  wire                       rst,
  // Host write stream
  input  wire                       wr_wren,
  input  host_bridge_pkg::xb_word_t wr_data,
  output logic                      wr_full,
  input  wire                       wr_open,
  // Host read stream
  input  wire                       rd_rden,
  output logic                      rd_empty,
  output host_bridge_pkg::xb_word_t rd_data,
  input  wire                       rd_open,
  output logic                      rd_eof,
  // Host loopback stream
  input  wire                       loop_rden,
  output logic                      loop_empty,
  output host_bridge_pkg::xb_word_t loop_data,
  output logic                      loop_eof,
  // Application side
  output host_bridge_pkg::xb_word_t pc_msg,
  output logic                      pc_msg_empty,
  input  wire                       pc_msg_ack,
  input  host_bridge_pkg::xb_word_t fpga_msg,
  input  wire                       fpga_msg_valid,
  output logic                      fpga_msg_full,
  output logic                      fpga_msg_lost,
  input  wire                       app_done
);

  // ************************************************************************
  // Host to application
  // ************************************************************************

  downstream_channel u_downstream (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .wr_wren      (wr_wren),
    .wr_data      (wr_data),
    .pc_msg_ack   (pc_msg_ack),
    .loop_rden    (loop_rden),
    .wr_full      (wr_full),
    .pc_msg       (pc_msg),
    .pc_msg_empty (pc_msg_empty),
    .loop_data    (loop_data),
    .loop_empty   (loop_empty)
  );

  // ************************************************************************
  // Application to host
  // ************************************************************************

  upstream_channel u_upstream (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .rd_open        (rd_open),
    .rd_rden        (rd_rden),
    .fpga_msg_full  (fpga_msg_full),
    .fpga_msg_lost  (fpga_msg_lost),
    .rd_data        (rd_data),
    .rd_empty       (rd_empty)
  );

  // End-of-file levels for the host link
  stream_eof_tracker u_eof (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .pc_msg       (pc_msg),
    .pc_msg_empty (pc_msg_empty),
    .rd_empty     (rd_empty),
    .rd_open      (rd_open),
    .app_done     (app_done),
    .wr_open      (wr_open),
    .loop_empty   (loop_empty),
    .rd_eof       (rd_eof),
    .loop_eof     (loop_eof)
  );

endmodule

`default_nettype wire

//--- hw/stream_eof_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module stream_eof_tracker (
  input  wire                       bus_clk,
  input  wire                       rst,
  input  host_bridge_pkg::xb_word_t pc_msg,
  input  wire                       pc_msg_empty,
  input  wire                       rd_empty,
  input  wire                       rd_open,
  input  wire                       app_done,
  input  wire                       wr_open,
  input  wire                       loop_empty,
  output logic                      rd_eof,
  output logic                      loop_eof
);

  logic term_at_head;

  // Terminator waiting at the head with nothing left for the host to read
  assign term_at_head = !pc_msg_empty && rd_empty &&
                        (pc_msg == host_bridge_pkg::TERMINATOR_WORD);

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_eof <= 1'b0;
    end else if (!rd_open) begin
      // Closing the read stream clears it, even over a new trigger
      rd_eof <= 1'b0;
    end else if (term_at_head || app_done) begin
      rd_eof <= 1'b1;
    end
  end

  // Host closed its writes and all loopback words are gone
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      loop_eof <= 1'b0;
    end else begin
      loop_eof <= !wr_open && loop_empty;
    end
  end

  a_eof_clears_on_close: assert property (
    @(posedge bus_clk) disable iff (rst) !rd_open |=> !rd_eof
  ) else $error("stream_eof_tracker: rd_eof held after rd_open low");

endmodule

`default_nettype wire

//--- hw/upstream_channel.sv
`default_nettype none
`timescale 1ns/1ps

module upstream_channel (
  input  wire                       bus_clk,
  input  wire                       rst,
  input  host_bridge_pkg::xb_word_t fpga_msg,
  input  wire                       fpga_msg_valid,
  input  wire                       rd_open,
  input  wire                       rd_rden,
  output logic                      fpga_msg_full,
  output logic                      fpga_msg_lost,
  output host_bridge_pkg::xb_word_t rd_data,
  output logic                      rd_empty
);

  logic push;

  // Words arriving while the host stream is closed are discarded
  assign push = fpga_msg_valid && rd_open;

  stream_fifo #(
    .DEPTH (host_bridge_pkg::RD_FIFO_DEPTH)
  ) u_rd_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (push && !fpga_msg_full),
    .din     (fpga_msg),
    .rd_en   (rd_rden),
    .dout    (rd_data),
    .full    (fpga_msg_full),
    .empty   (rd_empty)
  );

  // Sticky until reset, set by a push the FIFO could not take
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      fpga_msg_lost <= 1'b0;
    end else if (push && fpga_msg_full) begin
      fpga_msg_lost <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/downstream_channel.sv
`default_nettype none
`timescale 1ns/1ps

module downstream_channel (
  input  wire                       bus_clk,
  input  wire                       rst,
  input  wire                       wr_wren,
  input  host_bridge_pkg::xb_word_t wr_data,
  input  wire                       pc_msg_ack,
  input  wire                       loop_rden,
  output logic                      wr_full,
  output host_bridge_pkg::xb_word_t pc_msg,
  output logic                      pc_msg_empty,
  output host_bridge_pkg::xb_word_t loop_data,
  output logic                      loop_empty
);

  logic wr_empty;
  logic loop_full;

  // Host side write FIFO, words go straight to the application
  stream_fifo #(
    .DEPTH (host_bridge_pkg::WR_FIFO_DEPTH)
  ) u_wr_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (wr_wren && !wr_full),
    .din     (wr_data),
    .rd_en   (pc_msg_ack),
    .dout    (pc_msg),
    .full    (wr_full),
    .empty   (wr_empty)
  );

  // Hide the head word while the loopback copy has nowhere to go
  assign pc_msg_empty = wr_empty || loop_full;

  // Copy of every acknowledged word, taken on the ack edge
  stream_fifo #(
    .DEPTH (host_bridge_pkg::LOOP_FIFO_DEPTH)
  ) u_loop_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (pc_msg_ack),
    .din     (pc_msg),
    .rd_en   (loop_rden),
    .dout    (loop_data),
    .full    (loop_full),
    .empty   (loop_empty)
  );

  // Application must only ack a word it can see
  a_ack_only_when_avail: assert property (
    @(posedge bus_clk) disable iff (rst) pc_msg_ack |-> !pc_msg_empty
  ) else $error("downstream_channel: pc_msg_ack while pc_msg_empty");

endmodule

`default_nettype wire

//--- hw/stream_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module stream_fifo #(
  parameter int DEPTH = host_bridge_pkg::WR_FIFO_DEPTH
) (
  input  wire                       bus_clk,
  input  wire                       rst,
  input  wire                       wr_en,
  input  host_bridge_pkg::xb_word_t din,
  input  wire                       rd_en,
  output host_bridge_pkg::xb_word_t dout,
  output logic                      full,
  output logic                      empty
);

  localparam int AW = $clog2(DEPTH);

  // ************************************************************************
  // Storage and pointers
  // ************************************************************************

  host_bridge_pkg::xb_word_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // One bit wider than the pointers to tell full from empty
  logic [AW:0]   count;

  logic do_wr;
  logic do_rd;

  // Overflow and underflow are dropped here
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);

  // Head word is always on the output, no read strobe needed
  assign dout = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own since DEPTH is a power of two
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ************************************************************************
  // Caller protocol
  // ************************************************************************

  a_no_write_when_full: assert property (
    @(posedge bus_clk) disable iff (rst) !(wr_en && full)
  ) else $error("stream_fifo: write while full");

  a_no_read_when_empty: assert property (
    @(posedge bus_clk) disable iff (rst) !(rd_en && empty)
  ) else $error("stream_fifo: read while empty");

endmodule

`default_nettype wire

//--- hw/host_bridge_pkg.sv
`default_nettype none

package host_bridge_pkg;

  // ************************************************************************
  // Host link word
  // ************************************************************************

  localparam int XB_WORD_W = 32;

  typedef logic [XB_WORD_W-1:0] xb_word_t;

  // ************************************************************************
  // FIFO sizing
  // ************************************************************************

  // Depths must be powers of two
  localparam int WR_FIFO_DEPTH   = 16;
  // Kept below the write FIFO so loopback back-pressure can take effect
  localparam int LOOP_FIFO_DEPTH = 8;
  localparam int RD_FIFO_DEPTH   = 16;

  // All-ones word closes the downstream stream
  localparam xb_word_t TERMINATOR_WORD = '1;

endpackage

`default_nettype wire
